/* Makefile */
# Verilator build and run of the TQU testbench

VERILATOR ?= verilator
TOP       ?= tb_tqu
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

# build, run, then search the log for the fail message
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "=== FAIL ===" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* bench/tb_tqu.sv */
// random packets and pulls from a fixed-seed LFSR; needs a simulator with timing support
`timescale 1ns/1ps

module tb_tqu
    import egr_tqu_pkg::*;
();

    ////////////////////
    // run lengths
    ////////////////////

    localparam int RESET_TEST_LEN = 24;
    localparam int NUM_RAND_PKTS  = 200;
    localparam int NUM_BP_PKTS    = 12;
    localparam int NUM_LOAD_PKTS  = 30;
    localparam int TEST_LEN_TOTAL = RESET_TEST_LEN + NUM_RAND_PKTS + NUM_BP_PKTS + NUM_LOAD_PKTS;
    localparam int WATCHDOG_CYCLES = TEST_LEN_TOTAL * 20 + 1000;

    // longest tx silence tolerated while draining
    localparam int DRAIN_QUIET_MAX = 64;

    // expected tx entry
    typedef struct packed {
        data_word_t word;
        logic       ctrl;
        logic       eop;
    } exp_t;

    logic       clk;
    logic       rst_n;
    logic       rrsp_valid;
    word_type_t rrsp_type;
    logic       rrsp_eop;
    data_word_t rrsp_word;
    logic       rrsp_stall;
    logic       pkt_ready;
    logic       tcu_pull;
    logic       tx_valid;
    logic       tx_ctrl;
    logic       tx_eop;
    data_word_t tx_word;

    logic [31:0] lfsr = 32'h9fb3;
    exp_t        model_q[$];
    logic        pull_en = 1'b0;
    logic        phased = 1'b0;
    logic        in_pkt = 1'b0;
    logic        pull_pending = 1'b0;
    logic        eop_accepted = 1'b0;
    int          ctrl_due = 0;
    int          cycle_cnt = 0;
    int          step_cnt = 0;
    int          acc_cnt = 0;
    int          word_cnt = 0;
    int          err_cnt = 0;
    int          tests_run = 0;
    int          tests_failed = 0;

    tqu_top i_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .rrsp_valid (rrsp_valid),
        .rrsp_type  (rrsp_type),
        .rrsp_eop   (rrsp_eop),
        .rrsp_word  (rrsp_word),
        .rrsp_stall (rrsp_stall),
        .pkt_ready  (pkt_ready),
        .tcu_pull   (tcu_pull),
        .tx_valid   (tx_valid),
        .tx_ctrl    (tx_ctrl),
        .tx_eop     (tx_eop),
        .tx_word    (tx_word)
    );

    // 10 ns period
    always #5 clk = ~clk;

    ////////////////////
    // helpers
    ////////////////////

    // taps 32, 22, 2, 1
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        int          i;
        v = '0;
        for (i = 0; i < n; i++) begin
            v = {v[62:0], lfsr_bit()};
        end
        return v;
    endfunction

    task automatic report_mismatch(input string msg);
        err_cnt++;
        $display("FAIL t=%0t: %s", $time, msg);
    endtask

    task automatic report_problem(input string msg);
        err_cnt++;
        $display("error at time %0t: %s", $time, msg);
    endtask

    task automatic close_test(input string name, input int err_before);
        tests_run++;
        if (err_cnt != err_before) begin
            tests_failed++;
        end
        $display("test %s: %0d errors", name, err_cnt - err_before);
    endtask

    // one cycle with inputs moved 1 ns after the edge and the pull decided
    task automatic step();
        @(posedge clk);
        #1;
        step_cnt++;
        // phased mode drops pulls for part of every 160 cycles
        tcu_pull = pull_en && !(phased && (step_cnt % 160) < 48) && pkt_ready && lfsr_bit();
    endtask

    // wait out the stall, then present the word for one cycle
    task automatic send_word(input word_type_t wtype, input logic eop);
        while (rrsp_stall) begin
            step();
        end
        rrsp_valid = 1'b1;
        rrsp_type  = wtype;
        rrsp_eop   = eop;
        rrsp_word  = rand_bits(64);
        step();
        rrsp_valid = 1'b0;
    endtask

    // ctrl word, 1 to 4 data words, then an idle gap
    task automatic send_packet();
        int n_data;
        int gap;
        int i;
        n_data = 1 + int'(rand_bits(2));
        send_word(WORD_TYPE_CTRL, 1'b0);
        for (i = 0; i < n_data; i++) begin
            send_word(WORD_TYPE_DATA, i == n_data - 1);
        end
        gap = lfsr_bit() ? int'(rand_bits(2)) : 0;
        repeat (gap) step();
    endtask

    // pull until every accepted word is out or tx stays silent too long
    task automatic drain();
        int quiet;
        pull_en = 1'b1;
        quiet = 0;
        while ((model_q.size() != 0 || in_pkt || pull_pending) && quiet < DRAIN_QUIET_MAX) begin
            step();
            quiet = tx_valid ? 0 : quiet + 1;
        end
        assert (model_q.size() == 0 && !in_pkt && !pull_pending)
        else report_problem($sformatf("%0d accepted words never came out on tx",
            model_q.size()));
    endtask

    // with pulls off wait for a steady stall, then check nothing more gets in
    task automatic watch_backpressure();
        int run;
        int frozen;
        run = 0;
        while (run < 24) begin
            @(posedge clk);
            #2;
            run = rrsp_stall ? run + 1 : 0;
        end
        frozen = acc_cnt;
        repeat (16) begin
            @(posedge clk);
            #2;
        end
        assert (acc_cnt == frozen && rrsp_stall)
        else report_mismatch($sformatf("accepted %0d words while stalled", acc_cnt - frozen));
        pull_en = 1'b1;
    endtask

    ////////////////////
    // monitor and model
    ////////////////////

    always @(posedge clk) begin : monitor
        exp_t got;
        exp_t head;
        if (rst_n) begin
            // accepted response words go into the model
            if (rrsp_valid && !rrsp_stall) begin
                got.word = rrsp_word;
                got.ctrl = (rrsp_type == WORD_TYPE_CTRL);
                got.eop  = rrsp_eop;
                model_q.push_back(got);
                acc_cnt++;
                if (rrsp_eop) begin
                    eop_accepted = 1'b1;
                end
            end
            assert (!pkt_ready || eop_accepted)
            else report_problem("pkt_ready rose before any eop word was accepted");
            // word, ctrl and eop against the model head
            if (tx_valid) begin
                word_cnt++;
                assert (model_q.size() != 0)
                else report_problem("tx word while the model expects nothing");
                if (model_q.size() != 0) begin
                    head = model_q.pop_front();
                    assert (tx_word == head.word && tx_ctrl == head.ctrl && tx_eop == head.eop)
                    else report_mismatch($sformatf(
                        "tx %h ctrl %b eop %b, expected %h ctrl %b eop %b",
                        tx_word, tx_ctrl, tx_eop, head.word, head.ctrl, head.eop));
                end
            end
            // ctrl word due two edges after the pull
            if (tx_valid && tx_ctrl) begin
                assert (pull_pending && !in_pkt && cycle_cnt == ctrl_due)
                else report_mismatch($sformatf("ctrl word at cycle %0d, due at %0d",
                    cycle_cnt, ctrl_due));
                pull_pending = 1'b0;
                in_pkt = 1'b1;
            end else if (in_pkt) begin
                // data words back to back
                assert (tx_valid)
                else report_mismatch("gap between data words of one packet");
                if (!tx_valid || tx_eop) begin
                    in_pkt = 1'b0;
                end
            end else begin
                assert (!tx_valid)
                else report_problem("tx word outside any pulled packet");
            end
            if (tcu_pull) begin
                pull_pending = 1'b1;
                ctrl_due = cycle_cnt + 2;
            end
            cycle_cnt++;
        end
    end

    // bound on the whole run
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("=== FAIL ===");
        $finish;
    end

    ////////////////////
    // test sequence
    ////////////////////

    initial begin
        int err0;
        int i;
        clk        = 1'b0;
        rst_n      = 1'b0;
        rrsp_valid = 1'b0;
        rrsp_type  = WORD_TYPE_CTRL;
        rrsp_eop   = 1'b0;
        rrsp_word  = '0;
        tcu_pull   = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // reset values, then one packet with no pulls
        err0 = err_cnt;
        assert (!rrsp_stall && !pkt_ready && !tx_valid && !tx_ctrl && !tx_eop)
        else report_mismatch("outputs not low after reset");
        repeat (16) step();
        send_packet();
        repeat (4) step();
        assert (pkt_ready)
        else report_mismatch("pkt_ready low with a complete packet held");
        drain();
        close_test("reset", err0);

        // random packets with phased random pulls
        err0 = err_cnt;
        phased = 1'b1;
        for (i = 0; i < NUM_RAND_PKTS; i++) begin
            send_packet();
        end
        phased = 1'b0;
        drain();
        close_test("random traffic", err0);

        // fill until stalled, then release
        err0 = err_cnt;
        pull_en = 1'b0;
        fork
            begin
                for (i = 0; i < NUM_BP_PKTS; i++) begin
                    send_packet();
                end
            end
            watch_backpressure();
        join
        drain();
        close_test("backpressure", err0);

        // pulls always on while words keep arriving
        err0 = err_cnt;
        pull_en = 1'b1;
        for (i = 0; i < NUM_LOAD_PKTS; i++) begin
            send_packet();
        end
        drain();
        close_test("pull timing under load", err0);

        tcu_pull = 1'b0;
        $display("summary: %0d tests, %0d failed, %0d words checked, %0d errors",
            tests_run, tests_failed, word_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule : tb_tqu

/* rtl/egr_tqu_pkg.sv */
// single response port, single egress queue; bank depths are powers of two set by the addr widths
package egr_tqu_pkg;

    ////////////////////
    // word formats
    ////////////////////

    // one 64-bit word of packet content
    typedef logic [63:0] data_word_t;

    // word class, control (metadata) or data (payload)
    typedef logic word_type_t;

    localparam word_type_t WORD_TYPE_CTRL = 1'b0;
    localparam word_type_t WORD_TYPE_DATA = 1'b1;

    ////////////////////
    // bank geometry
    ////////////////////

    localparam int CTRL_ADDR_W = 3;
    localparam int DATA_ADDR_W = 4;

    // entries per bank
    localparam int CTRL_DEPTH = 1 << CTRL_ADDR_W;
    localparam int DATA_DEPTH = 1 << DATA_ADDR_W;

    typedef logic [CTRL_ADDR_W-1:0] ctrl_addr_t;
    typedef logic [DATA_ADDR_W-1:0] data_addr_t;

    // occupancy, one extra bit to hold the full value
    typedef logic [CTRL_ADDR_W:0] ctrl_cnt_t;
    typedef logic [DATA_ADDR_W:0] data_cnt_t;

    // complete packets held, bounded by the ctrl depth
    typedef logic [3:0] pkt_cnt_t;

    ////////////////////
    // pull sequencer
    ////////////////////

    typedef enum logic [1:0] {
        PULL_IDLE,
        PULL_CTRL,
        PULL_DATA
    } pull_state_e;

endpackage : egr_tqu_pkg

/* rtl/tqu_buf_ctrl.sv */
// no back-pressure on tx; tcu_pull only while pkt_ready, reads win over writes on each bank
`timescale 1ns/1ps

module tqu_buf_ctrl
    import egr_tqu_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,

    // hold stage
    input  logic        hold_valid,
    input  word_type_t  hold_type,
    input  logic        hold_eop,
    input  data_word_t  hold_word,
    output logic        hold_taken,
    output logic        ctrl_full,
    output logic        data_full,

    // control bank
    output ctrl_addr_t  ctrl_addr,
    output logic        ctrl_wr_en,
    output logic        ctrl_rd_en,
    output data_word_t  ctrl_wr_word,
    input  data_word_t  ctrl_rd_word,

    // data bank
    output data_addr_t  data_addr,
    output logic        data_wr_en,
    output logic        data_rd_en,
    output data_word_t  data_wr_word,
    input  data_word_t  data_rd_word,

    // transmit controller
    input  logic        tcu_pull,
    output logic        pkt_ready,
    output logic        tx_valid,
    output logic        tx_ctrl,
    output logic        tx_eop,
    output data_word_t  tx_word
);

    ctrl_addr_t              ctrl_wr_ptr;
    ctrl_addr_t              ctrl_rd_ptr;
    ctrl_cnt_t               ctrl_cnt;
    data_addr_t              data_wr_ptr;
    data_addr_t              data_rd_ptr;
    data_cnt_t               data_cnt;
    logic [DATA_DEPTH-1:0]   eop_flags;
    pkt_cnt_t                pkt_cnt;
    pull_state_e             state;
    pull_state_e             state_nxt;
    logic                    rd_last;

    ////////////////////
    // write side
    ////////////////////

    // held word waits while its bank is being read
    assign ctrl_wr_en = hold_valid && (hold_type == WORD_TYPE_CTRL) && !ctrl_rd_en;
    assign data_wr_en = hold_valid && (hold_type == WORD_TYPE_DATA) && !data_rd_en;
    assign hold_taken = ctrl_wr_en || data_wr_en;

    assign ctrl_wr_word = hold_word;
    assign data_wr_word = hold_word;

    // read pointer wins the single address port
    assign ctrl_addr = ctrl_rd_en ? ctrl_rd_ptr : ctrl_wr_ptr;
    assign data_addr = data_rd_en ? data_rd_ptr : data_wr_ptr;

    // one entry kept spare for the word sitting in the hold stage
    assign ctrl_full = ctrl_cnt >= ctrl_cnt_t'(CTRL_DEPTH - 1);
    assign data_full = data_cnt >= data_cnt_t'(DATA_DEPTH - 1);

    ////////////////////
    // pointers, counts
    ////////////////////

    // last word of the packet when the flagged entry is read
    assign rd_last = data_rd_en && eop_flags[data_rd_ptr];

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            ctrl_wr_ptr <= '0;
            ctrl_rd_ptr <= '0;
            ctrl_cnt    <= '0;
            data_wr_ptr <= '0;
            data_rd_ptr <= '0;
            data_cnt    <= '0;
            eop_flags   <= '0;
            pkt_cnt     <= '0;
        end else begin
            if (ctrl_wr_en) begin
                ctrl_wr_ptr <= ctrl_wr_ptr + 1'b1;
                ctrl_cnt    <= ctrl_cnt + 1'b1;
            end else if (ctrl_rd_en) begin
                ctrl_rd_ptr <= ctrl_rd_ptr + 1'b1;
                ctrl_cnt    <= ctrl_cnt - 1'b1;
            end
            // write and read never meet on the data bank
            if (data_wr_en) begin
                data_wr_ptr            <= data_wr_ptr + 1'b1;
                data_cnt               <= data_cnt + 1'b1;
                eop_flags[data_wr_ptr] <= hold_eop;
            end else if (data_rd_en) begin
                data_rd_ptr <= data_rd_ptr + 1'b1;
                data_cnt    <= data_cnt - 1'b1;
            end
            // packet counted once its eop word sits in the bank
            if (data_wr_en && hold_eop) begin
                pkt_cnt <= pkt_cnt + 1'b1;
            end else if (rd_last) begin
                pkt_cnt <= pkt_cnt - 1'b1;
            end
        end
    end

    ////////////////////
    // pull FSM
    ////////////////////

    always_comb begin
        state_nxt = state;
        unique case (state)
            PULL_IDLE: if (tcu_pull) state_nxt = PULL_CTRL;
            PULL_CTRL: state_nxt = PULL_DATA;
            PULL_DATA: if (rd_last) state_nxt = PULL_IDLE;
            default:   state_nxt = PULL_IDLE;
        endcase
    end

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            state <= PULL_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // one ctrl read, then data reads until the eop entry
    assign ctrl_rd_en = (state == PULL_CTRL);
    assign data_rd_en = (state == PULL_DATA);
    assign pkt_ready  = (pkt_cnt != '0) && (state == PULL_IDLE);

    ////////////////////
    // tx stage
    ////////////////////

    // strobes delayed to line up with bank read data
    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            tx_valid <= 1'b0;
            tx_ctrl  <= 1'b0;
            tx_eop   <= 1'b0;
        end else begin
            tx_valid <= ctrl_rd_en || data_rd_en;
            tx_ctrl  <= ctrl_rd_en;
            tx_eop   <= rd_last;
        end
    end

    assign tx_word = tx_ctrl ? ctrl_rd_word : data_rd_word;

    // pull only offered with a whole packet stored and the FSM idle
    a_pull_when_ready: assert property (
        @(posedge clk) disable iff (!rst_n) tcu_pull |-> pkt_ready
    ) else $error("tcu_pull without pkt_ready");

    // stall path must keep both banks from overflowing
    a_occupancy: assert property (
        @(posedge clk) disable iff (!rst_n)
        (ctrl_cnt <= ctrl_cnt_t'(CTRL_DEPTH)) && (data_cnt <= data_cnt_t'(DATA_DEPTH))
    ) else $error("bank occupancy above depth");

endmodule : tqu_buf_ctrl

/* rtl/tqu_pkt_buf.sv */
// single address port; caller must never read and write in one cycle, rd_word holds between reads
`timescale 1ns/1ps

module tqu_pkt_buf
    import egr_tqu_pkg::*;
#(
    parameter int ADDR_W = 3
)
(
    input  logic              clk,
    input  logic [ADDR_W-1:0] addr,
    input  logic              wr_en,
    input  logic              rd_en,
    input  data_word_t        wr_word,
    output data_word_t        rd_word
);

    localparam int DEPTH = 1 << ADDR_W;

    ////////////////////
    // storage
    ////////////////////

    data_word_t mem [DEPTH];

    // synchronous write
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[addr] <= wr_word;
        end
    end

    // registered read, data one cycle after rd_en
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_word <= mem[addr];
        end
    end

    // one address port, so arbitration upstream must pick one
    a_port_excl: assert property (
        @(posedge clk) !(wr_en && rd_en)
    ) else $error("bank read and write in the same cycle");

endmodule : tqu_pkt_buf

/* rtl/tqu_rrsp_rcv.sv */
// one-entry hold stage; the source must keep rrsp_valid low while it sees rrsp_stall
`timescale 1ns/1ps

module tqu_rrsp_rcv
    import egr_tqu_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,

    // read response port
    input  logic       rrsp_valid,
    input  word_type_t rrsp_type,
    input  logic       rrsp_eop,
    input  data_word_t rrsp_word,
    output logic       rrsp_stall,

    // towards the buffer controller
    output logic       hold_valid,
    output word_type_t hold_type,
    output logic       hold_eop,
    output data_word_t hold_word,
    input  logic       hold_taken,
    input  logic       ctrl_full,
    input  logic       data_full
);

    logic accept;

    ////////////////////
    // accept and hold
    ////////////////////

    // a new word may land in the same cycle the old one is written
    assign accept = rrsp_valid && !rrsp_stall;

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            hold_valid <= 1'b0;
        end else if (accept) begin
            hold_valid <= 1'b1;
        end else if (hold_taken) begin
            hold_valid <= 1'b0;
        end
    end

    // payload side, type picks the bank downstream
    always_ff @(posedge clk) begin
        if (accept) begin
            hold_type <= rrsp_type;
            hold_eop  <= rrsp_eop;
            hold_word <= rrsp_word;
        end
    end

    ////////////////////
    // stall
    ////////////////////

    // held word blocked by a read, or either bank nearly full
    assign rrsp_stall = (hold_valid && !hold_taken) || ctrl_full || data_full;

    // source side must honour the stall, otherwise a word is dropped
    a_no_valid_in_stall: assert property (
        @(posedge clk) disable iff (!rst_n) rrsp_valid |-> !rrsp_stall
    ) else $error("rrsp_valid raised while rrsp_stall is high");

endmodule : tqu_rrsp_rcv

/* rtl/tqu_top.sv */
// tag queuing unit, one response port, one egress queue, no back-pressure on tx
`timescale 1ns/1ps

module tqu_top
    import egr_tqu_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,

    // read response side
    input  logic       rrsp_valid,
    input  word_type_t rrsp_type,
    input  logic       rrsp_eop,
    input  data_word_t rrsp_word,
    output logic       rrsp_stall,

    // transmit side
    output logic       pkt_ready,
    input  logic       tcu_pull,
    output logic       tx_valid,
    output logic       tx_ctrl,
    output logic       tx_eop,
    output data_word_t tx_word
);

    // hold stage to controller
    logic       hold_valid;
    word_type_t hold_type;
    logic       hold_eop;
    data_word_t hold_word;
    logic       hold_taken;
    logic       ctrl_full;
    logic       data_full;

    // bank ports
    ctrl_addr_t ctrl_addr;
    logic       ctrl_wr_en;
    logic       ctrl_rd_en;
    data_word_t ctrl_wr_word;
    data_word_t ctrl_rd_word;
    data_addr_t data_addr;
    logic       data_wr_en;
    logic       data_rd_en;
    data_word_t data_wr_word;
    data_word_t data_rd_word;

    tqu_rrsp_rcv i_rcv (
        .clk        (clk),
        .rst_n      (rst_n),
        .rrsp_valid (rrsp_valid),
        .rrsp_type  (rrsp_type),
        .rrsp_eop   (rrsp_eop),
        .rrsp_word  (rrsp_word),
        .rrsp_stall (rrsp_stall),
        .hold_valid (hold_valid),
        .hold_type  (hold_type),
        .hold_eop   (hold_eop),
        .hold_word  (hold_word),
        .hold_taken (hold_taken),
        .ctrl_full  (ctrl_full),
        .data_full  (data_full)
    );

    tqu_buf_ctrl i_buf_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .hold_valid   (hold_valid),
        .hold_type    (hold_type),
        .hold_eop     (hold_eop),
        .hold_word    (hold_word),
        .hold_taken   (hold_taken),
        .ctrl_full    (ctrl_full),
        .data_full    (data_full),
        .ctrl_addr    (ctrl_addr),
        .ctrl_wr_en   (ctrl_wr_en),
        .ctrl_rd_en   (ctrl_rd_en),
        .ctrl_wr_word (ctrl_wr_word),
        .ctrl_rd_word (ctrl_rd_word),
        .data_addr    (data_addr),
        .data_wr_en   (data_wr_en),
        .data_rd_en   (data_rd_en),
        .data_wr_word (data_wr_word),
        .data_rd_word (data_rd_word),
        .tcu_pull     (tcu_pull),
        .pkt_ready    (pkt_ready),
        .tx_valid     (tx_valid),
        .tx_ctrl      (tx_ctrl),
        .tx_eop       (tx_eop),
        .tx_word      (tx_word)
    );

    // metadata bank
    tqu_pkt_buf #(.ADDR_W(CTRL_ADDR_W)) i_ctrl_buf (
        .clk     (clk),
        .addr    (ctrl_addr),
        .wr_en   (ctrl_wr_en),
        .rd_en   (ctrl_rd_en),
        .wr_word (ctrl_wr_word),
        .rd_word (ctrl_rd_word)
    );

    // payload bank
    tqu_pkt_buf #(.ADDR_W(DATA_ADDR_W)) i_data_buf (
        .clk     (clk),
        .addr    (data_addr),
        .wr_en   (data_wr_en),
        .rd_en   (data_rd_en),
        .wr_word (data_wr_word),
        .rd_word (data_rd_word)
    );

endmodule : tqu_top

/* sources.f */
rtl/egr_tqu_pkg.sv
rtl/tqu_rrsp_rcv.sv
rtl/tqu_pkt_buf.sv
rtl/tqu_buf_ctrl.sv
rtl/tqu_top.sv
bench/tb_tqu.sv
